//--- hdl/rvv_cfg_pkg.sv
// Vector configuration types
package rvv_cfg_pkg;

  // Scalar register value, also used for AVL, vl and VLMAX
  typedef logic [31:0] xlen_t;

  // Element width, codes 3 to 7 are illegal
  typedef enum logic [2:0] {
    SEW8  = 3'd0,
    SEW16 = 3'd1,
    SEW32 = 3'd2
  } sew_e;

  // Register group multiplier, fractional settings use the upper codes
  typedef enum logic [2:0] {
    LMUL1     = 3'd0,
    LMUL2     = 3'd1,
    LMUL4     = 3'd2,
    LMUL8     = 3'd3,
    LMUL_RSVD = 3'd4,
    LMUL1_8   = 3'd5,
    LMUL1_4   = 3'd6,
    LMUL1_2   = 3'd7
  } lmul_e;

  // vtype CSR low byte
  typedef logic [7:0] vtype_t;

  localparam int VT_LMUL_LSB = 0;
  localparam int VT_SEW_LSB  = 3;
  localparam int VT_TA_BIT   = 6;
  localparam int VT_MA_BIT   = 7;

  // Recommended reset state, vill set and everything else cleared
  localparam xlen_t RST_VL   = '0;
  localparam sew_e  RST_SEW  = SEW8;
  localparam lmul_e RST_LMUL = LMUL1;
  localparam logic  RST_TA   = 1'b0;
  localparam logic  RST_MA   = 1'b0;
  localparam logic  RST_VILL = 1'b1;

endpackage

//--- hdl/rvv_inst_pkg.sv
// Vector instruction and command formats
package rvv_inst_pkg;

  // Raw 32-bit instruction word
  typedef logic [31:0] inst_t;

  // Scalar register index
  typedef logic [4:0] reg_addr_t;

  // Field positions inside the instruction word
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int VTYPE_LSB  = 20;
  // Top of the vset* selector bits
  localparam int SEL_MSB    = 31;

  // funct3 major groups
  localparam logic [2:0] OPCFG = 3'b111;
  localparam logic [2:0] OPIVX = 3'b100;
  localparam logic [2:0] OPMVX = 3'b110;

  // Command word is instruction, rs1, vl, sew and lmul from msb to lsb
  localparam int CMD_W        = 32 + 32 + 32 + 3 + 3;
  localparam int CMD_LMUL_LSB = 0;
  localparam int CMD_SEW_LSB  = 3;
  localparam int CMD_VL_LSB   = 6;
  localparam int CMD_RS1_LSB  = 38;
  localparam int CMD_INST_LSB = 70;

  typedef logic [CMD_W-1:0] cmd_t;

endpackage

//--- hdl/rvv_vtype_unit.sv
// Vector configuration unit
`timescale 1ns/1ns

module rvv_vtype_unit
  import rvv_cfg_pkg::*;
  import rvv_inst_pkg::*;
#(
  parameter int VLEN        = 128,
  parameter int REDUCE_LMUL = 1
) (
  input  logic  clk,
  input  logic  rstn,
  input  logic  slot_valid_i,
  input  inst_t inst_i,
  input  xlen_t rs1_data_i,
  input  xlen_t rs2_data_i,
  input  logic  rs1_valid_i,
  input  logic  rs2_valid_i,
  output logic  is_cfg_o,
  output xlen_t new_vl_o,
  output xlen_t vl_o,
  output sew_e  sew_o,
  output lmul_e lmul_o,
  output logic  ta_o,
  output logic  ma_o,
  output logic  vill_o
);

  xlen_t      vl_q;
  sew_e       sew_q;
  lmul_e      lmul_q;
  logic       ta_q;
  logic       ma_q;
  logic       vill_q;

  logic [2:0] funct3;
  reg_addr_t  rd_idx;
  reg_addr_t  rs1_idx;
  logic       is_vsetvli;
  logic       is_vsetivli;
  logic       is_vsetvl;
  vtype_t     vtype;
  sew_e       vt_sew;
  lmul_e      vt_lmul;
  logic       vt_vill;
  xlen_t      avl;
  xlen_t      vlmax;
  xlen_t      new_vl;
  lmul_e      cand;
  lmul_e      red_lmul;
  logic       found;

  // VLMAX = VLEN/8 * LMUL >> sew
  function automatic xlen_t calc_vlmax(sew_e sew, lmul_e lmul);
    xlen_t base;
    base = xlen_t'(VLEN / 8);
    case (lmul)
      LMUL1_8: base = base >> 3;
      LMUL1_4: base = base >> 2;
      LMUL1_2: base = base >> 1;
      LMUL2:   base = base << 1;
      LMUL4:   base = base << 2;
      LMUL8:   base = base << 3;
      LMUL_RSVD: base = '0;
      default: base = base;
    endcase
    return base >> sew;
  endfunction

  // Fractional LMUL may not go below SEW/32
  function automatic logic vtype_legal(sew_e sew, lmul_e lmul);
    logic ok;
    case (sew)
      SEW8:    ok = !(lmul inside {LMUL_RSVD, LMUL1_8});
      SEW16:   ok = !(lmul inside {LMUL_RSVD, LMUL1_8, LMUL1_4});
      SEW32:   ok = !(lmul inside {LMUL_RSVD, LMUL1_8, LMUL1_4, LMUL1_2});
      default: ok = 1'b0;
    endcase
    return ok;
  endfunction

  assign funct3      = inst_i[FUNCT3_LSB +: 3];
  assign rd_idx      = inst_i[RD_LSB +: 5];
  assign rs1_idx     = inst_i[RS1_LSB +: 5];
  assign is_vsetvli  = (inst_i[SEL_MSB] == 1'b0);
  assign is_vsetivli = (inst_i[SEL_MSB -: 2] == 2'b11);
  assign is_vsetvl   = (inst_i[SEL_MSB -: 7] == 7'b1000000);
  assign is_cfg_o    = (funct3 == OPCFG) && (is_vsetvli || is_vsetivli || is_vsetvl);

  // vsetvl takes vtype from rs2, the others from the immediate
  assign vtype   = is_vsetvl ? vtype_t'(rs2_data_i[7:0]) : inst_i[VTYPE_LSB +: 8];
  assign vt_sew  = sew_e'(vtype[VT_SEW_LSB +: 3]);
  assign vt_lmul = lmul_e'(vtype[VT_LMUL_LSB +: 3]);
  assign vt_vill = !vtype_legal(vt_sew, vt_lmul);
  assign vlmax   = calc_vlmax(vt_sew, vt_lmul);

  // AVL selection
  always_comb begin
    if (is_vsetivli) begin
      avl = xlen_t'(rs1_idx);
    end else if (rs1_idx != '0) begin
      avl = rs1_data_i;
    end else if (rd_idx != '0) begin
      avl = '1;
    end else begin
      avl = vl_q;
    end
  end

  assign new_vl   = vt_vill ? '0 : ((avl < vlmax) ? avl : vlmax);
  assign new_vl_o = new_vl;

  // Smallest legal LMUL that still holds vl, candidates in ascending order
  always_comb begin
    red_lmul = vt_lmul;
    found    = 1'b0;
    cand     = LMUL1_8;
    for (int k = 0; k < 7; k++) begin
      cand = lmul_e'(3'(k + 5));
      if (!found && vtype_legal(vt_sew, cand) && (calc_vlmax(vt_sew, cand) >= new_vl)) begin
        red_lmul = cand;
        found    = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      vl_q   <= RST_VL;
      sew_q  <= RST_SEW;
      lmul_q <= RST_LMUL;
      ta_q   <= RST_TA;
      ma_q   <= RST_MA;
      vill_q <= RST_VILL;
    end else if (slot_valid_i && is_cfg_o) begin
      vl_q   <= new_vl;
      vill_q <= vt_vill;
      if (vt_vill) begin
        // Illegal vtype clears the remaining fields
        sew_q  <= RST_SEW;
        lmul_q <= RST_LMUL;
        ta_q   <= RST_TA;
        ma_q   <= RST_MA;
      end else begin
        sew_q  <= vt_sew;
        lmul_q <= (REDUCE_LMUL != 0) ? red_lmul : vt_lmul;
        ta_q   <= vtype[VT_TA_BIT];
        ma_q   <= vtype[VT_MA_BIT];
      end
    end
  end

  assign vl_o   = vl_q;
  assign sew_o  = sew_q;
  assign lmul_o = lmul_q;
  assign ta_o   = ta_q;
  assign ma_o   = ma_q;
  assign vill_o = vill_q;

  // Scalar operands must arrive with the held configuration instruction
  a_cfg_rs1: assert property (@(posedge clk) disable iff (!rstn)
    (slot_valid_i && is_cfg_o && !is_vsetivli && (rs1_idx != '0)) |-> rs1_valid_i);
  a_cfg_rs2: assert property (@(posedge clk) disable iff (!rstn)
    (slot_valid_i && is_cfg_o && is_vsetvl) |-> rs2_valid_i);

endmodule

//--- hdl/rvv_dispatch_stage.sv
// Instruction dispatch stage
`timescale 1ns/1ns

module rvv_dispatch_stage
  import rvv_cfg_pkg::*;
  import rvv_inst_pkg::*;
#(
  parameter int VLEN        = 128,
  parameter int REDUCE_LMUL = 1,
  parameter int CMD_DEPTH   = 4,
  localparam int CNT_W      = $clog2(CMD_DEPTH + 1)
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             inst_valid_i,
  input  inst_t            inst_data_i,
  output logic             inst_ready_o,
  input  logic             rs1_valid_i,
  input  xlen_t            rs1_data_i,
  input  logic             rs2_valid_i,
  input  xlen_t            rs2_data_i,
  input  logic [CNT_W-1:0] fifo_count_i,
  output logic             push_o,
  output cmd_t             push_data_o,
  output logic             reg_write_valid_o,
  output reg_addr_t        reg_write_addr_o,
  output xlen_t            reg_write_data_o,
  output logic             trap_valid_o,
  output inst_t            trap_inst_o,
  output logic             config_valid_o,
  output xlen_t            cfg_vl_o,
  output sew_e             cfg_sew_o,
  output lmul_e            cfg_lmul_o,
  output logic             cfg_ta_o,
  output logic             cfg_ma_o,
  output logic             cfg_vill_o
);

  logic             slot_valid_q;
  inst_t            slot_inst_q;
  logic [CNT_W-1:0] free_slots;
  logic             is_cfg;
  xlen_t            new_vl;
  logic             needs_rs1;

  // Keep room in the FIFO for whatever is already in the slot
  assign free_slots   = CNT_W'(CMD_DEPTH) - fifo_count_i;
  assign inst_ready_o = (free_slots > CNT_W'(slot_valid_q));

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      slot_valid_q <= 1'b0;
    end else begin
      slot_valid_q <= inst_valid_i && inst_ready_o;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid_i && inst_ready_o) begin
      slot_inst_q <= inst_data_i;
    end
  end

  rvv_vtype_unit #(
    .VLEN        (VLEN),
    .REDUCE_LMUL (REDUCE_LMUL)
  ) vtype0 (
    .clk          (clk),
    .rstn         (rstn),
    .slot_valid_i (slot_valid_q),
    .inst_i       (slot_inst_q),
    .rs1_data_i   (rs1_data_i),
    .rs2_data_i   (rs2_data_i),
    .rs1_valid_i  (rs1_valid_i),
    .rs2_valid_i  (rs2_valid_i),
    .is_cfg_o     (is_cfg),
    .new_vl_o     (new_vl),
    .vl_o         (cfg_vl_o),
    .sew_o        (cfg_sew_o),
    .lmul_o       (cfg_lmul_o),
    .ta_o         (cfg_ta_o),
    .ma_o         (cfg_ma_o),
    .vill_o       (cfg_vill_o)
  );

  // Configuration results go back to rd
  assign reg_write_valid_o = slot_valid_q && is_cfg;
  assign reg_write_addr_o  = slot_inst_q[RD_LSB +: 5];
  assign reg_write_data_o  = new_vl;

  assign trap_valid_o   = slot_valid_q && !is_cfg && cfg_vill_o;
  assign trap_inst_o    = slot_inst_q;
  assign config_valid_o = !slot_valid_q;

  // Only the vector-scalar groups carry rs1
  assign needs_rs1 = (slot_inst_q[FUNCT3_LSB +: 3] == OPIVX) ||
                     (slot_inst_q[FUNCT3_LSB +: 3] == OPMVX);

  assign push_o = slot_valid_q && !is_cfg && !cfg_vill_o;

  always_comb begin
    push_data_o = '0;
    push_data_o[CMD_INST_LSB +: 32] = slot_inst_q;
    push_data_o[CMD_RS1_LSB +: 32]  = needs_rs1 ? rs1_data_i : '0;
    push_data_o[CMD_VL_LSB +: 32]   = cfg_vl_o;
    push_data_o[CMD_SEW_LSB +: 3]   = cfg_sew_o;
    push_data_o[CMD_LMUL_LSB +: 3]  = cfg_lmul_o;
  end

  a_vx_rs1: assert property (@(posedge clk) disable iff (!rstn)
    (slot_valid_q && needs_rs1) |-> rs1_valid_i);

endmodule

//--- hdl/rvv_cmd_fifo.sv
// Vector command FIFO
`timescale 1ns/1ns

module rvv_cmd_fifo
  import rvv_cfg_pkg::*;
  import rvv_inst_pkg::*;
#(
  parameter int CMD_DEPTH = 4,
  localparam int CNT_W    = $clog2(CMD_DEPTH + 1),
  localparam int PTR_W    = (CMD_DEPTH > 1) ? $clog2(CMD_DEPTH) : 1
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             push_i,
  input  cmd_t             push_data_i,
  input  logic             cmd_ready_i,
  output logic [CNT_W-1:0] count_o,
  output logic             cmd_valid_o,
  output inst_t            cmd_inst_o,
  output xlen_t            cmd_rs1_o,
  output xlen_t            cmd_vl_o,
  output sew_e             cmd_sew_o,
  output lmul_e            cmd_lmul_o
);

  typedef logic [PTR_W-1:0] ptr_t;

  cmd_t             mem [CMD_DEPTH];
  ptr_t             wr_ptr_q;
  ptr_t             rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             pop;
  cmd_t             head;

  // Wrap explicitly so any depth works
  function automatic ptr_t next_ptr(ptr_t p);
    return (p == ptr_t'(CMD_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign pop = cmd_valid_o && cmd_ready_i;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  assign count_o     = count_q;
  assign cmd_valid_o = (count_q != '0);
  assign head        = mem[rd_ptr_q];
  assign cmd_inst_o  = head[CMD_INST_LSB +: 32];
  assign cmd_rs1_o   = head[CMD_RS1_LSB +: 32];
  assign cmd_vl_o    = head[CMD_VL_LSB +: 32];
  assign cmd_sew_o   = sew_e'(head[CMD_SEW_LSB +: 3]);
  assign cmd_lmul_o  = lmul_e'(head[CMD_LMUL_LSB +: 3]);

  // Dispatch ready logic must never let the buffer overflow
  a_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
    push_i |-> (count_q != CNT_W'(CMD_DEPTH)));

endmodule

//--- hdl/rvv_front_end.sv
// Vector configuration front end
`timescale 1ns/1ns

module rvv_front_end
  import rvv_cfg_pkg::*;
  import rvv_inst_pkg::*;
#(
  parameter int VLEN        = 128,
  parameter int REDUCE_LMUL = 1,
  parameter int CMD_DEPTH   = 4
) (
  input  logic      clk,
  input  logic      rstn,
  input  logic      inst_valid_i,
  input  inst_t     inst_data_i,
  output logic      inst_ready_o,
  input  logic      rs1_valid_i,
  input  xlen_t     rs1_data_i,
  input  logic      rs2_valid_i,
  input  xlen_t     rs2_data_i,
  output logic      reg_write_valid_o,
  output reg_addr_t reg_write_addr_o,
  output xlen_t     reg_write_data_o,
  output logic      trap_valid_o,
  output inst_t     trap_inst_o,
  output logic      config_valid_o,
  output xlen_t     cfg_vl_o,
  output sew_e      cfg_sew_o,
  output lmul_e     cfg_lmul_o,
  output logic      cfg_ta_o,
  output logic      cfg_ma_o,
  output logic      cfg_vill_o,
  output logic      cmd_valid_o,
  output inst_t     cmd_inst_o,
  output xlen_t     cmd_rs1_o,
  output xlen_t     cmd_vl_o,
  output sew_e      cmd_sew_o,
  output lmul_e     cmd_lmul_o,
  input  logic      cmd_ready_i
);

  localparam int CNT_W = $clog2(CMD_DEPTH + 1);

  logic             push;
  cmd_t             push_data;
  logic [CNT_W-1:0] fifo_count;

  rvv_dispatch_stage #(
    .VLEN        (VLEN),
    .REDUCE_LMUL (REDUCE_LMUL),
    .CMD_DEPTH   (CMD_DEPTH)
  ) dispatch0 (
    .clk               (clk),
    .rstn              (rstn),
    .inst_valid_i      (inst_valid_i),
    .inst_data_i       (inst_data_i),
    .inst_ready_o      (inst_ready_o),
    .rs1_valid_i       (rs1_valid_i),
    .rs1_data_i        (rs1_data_i),
    .rs2_valid_i       (rs2_valid_i),
    .rs2_data_i        (rs2_data_i),
    .fifo_count_i      (fifo_count),
    .push_o            (push),
    .push_data_o       (push_data),
    .reg_write_valid_o (reg_write_valid_o),
    .reg_write_addr_o  (reg_write_addr_o),
    .reg_write_data_o  (reg_write_data_o),
    .trap_valid_o      (trap_valid_o),
    .trap_inst_o       (trap_inst_o),
    .config_valid_o    (config_valid_o),
    .cfg_vl_o          (cfg_vl_o),
    .cfg_sew_o         (cfg_sew_o),
    .cfg_lmul_o        (cfg_lmul_o),
    .cfg_ta_o          (cfg_ta_o),
    .cfg_ma_o          (cfg_ma_o),
    .cfg_vill_o        (cfg_vill_o)
  );

  rvv_cmd_fifo #(
    .CMD_DEPTH (CMD_DEPTH)
  ) fifo0 (
    .clk         (clk),
    .rstn        (rstn),
    .push_i      (push),
    .push_data_i (push_data),
    .cmd_ready_i (cmd_ready_i),
    .count_o     (fifo_count),
    .cmd_valid_o (cmd_valid_o),
    .cmd_inst_o  (cmd_inst_o),
    .cmd_rs1_o   (cmd_rs1_o),
    .cmd_vl_o    (cmd_vl_o),
    .cmd_sew_o   (cmd_sew_o),
    .cmd_lmul_o  (cmd_lmul_o)
  );

endmodule

//--- verif/tb_rvv_front_end.sv
// Vector front end testbench
`timescale 1ns/1ns

module tb_rvv_front_end;

  localparam int VLEN        = 128;
  localparam int REDUCE_LMUL = 1;
  localparam int CMD_DEPTH   = 4;
  localparam int WAIT_LIMIT  = 200;
  localparam int N_MAIN      = 13;
  localparam int K_WB        = 0;
  localparam int K_CMD       = 1;
  localparam int K_TRAP      = 2;

  logic        clk;
  logic        rstn;
  logic        inst_valid_i;
  logic [31:0] inst_data_i;
  logic        inst_ready_o;
  logic        rs1_valid_i;
  logic [31:0] rs1_data_i;
  logic        rs2_valid_i;
  logic [31:0] rs2_data_i;
  logic        reg_write_valid_o;
  logic [4:0]  reg_write_addr_o;
  logic [31:0] reg_write_data_o;
  logic        trap_valid_o;
  logic [31:0] trap_inst_o;
  logic        config_valid_o;
  logic [31:0] cfg_vl_o;
  logic [2:0]  cfg_sew_o;
  logic [2:0]  cfg_lmul_o;
  logic        cfg_ta_o;
  logic        cfg_ma_o;
  logic        cfg_vill_o;
  logic        cmd_valid_o;
  logic [31:0] cmd_inst_o;
  logic [31:0] cmd_rs1_o;
  logic [31:0] cmd_vl_o;
  logic [2:0]  cmd_sew_o;
  logic [2:0]  cmd_lmul_o;
  logic        cmd_ready_i;

  // Stimulus table with one row per test
  string       t_name [32];
  logic [31:0] t_inst [32];
  logic [31:0] t_rs1 [32];
  logic [31:0] t_rs2 [32];
  int          t_kind [32];
  logic [31:0] t_vl [32];
  logic [2:0]  t_sew [32];
  logic [2:0]  t_lmul [32];
  logic        t_vill [32];
  logic        t_ta [32];
  logic        t_ma [32];
  logic [31:0] t_cmd_rs1 [32];
  int          row_fails [32];
  int          n_rows;

  // Rows whose command has not come out yet in issue order
  int          exp_q [$];
  logic        stall_hold;
  logic        timed_out;
  int          errors;
  int          tests;
  logic [31:0] rnd_state;

  rvv_front_end #(
    .VLEN        (VLEN),
    .REDUCE_LMUL (REDUCE_LMUL),
    .CMD_DEPTH   (CMD_DEPTH)
  ) dut0 (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] enc_vsetvli(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [7:0] vtype);
    return {1'b0, 3'b000, vtype, rs1, 3'b111, rd, 7'h57};
  endfunction

  function automatic logic [31:0] enc_vsetivli(input logic [4:0] rd, input logic [4:0] uimm,
                                               input logic [7:0] vtype);
    return {2'b11, 2'b00, vtype, uimm, 3'b111, rd, 7'h57};
  endfunction

  function automatic logic [31:0] enc_vsetvl(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [4:0] rs2);
    return {7'b1000000, rs2, rs1, 3'b111, rd, 7'h57};
  endfunction

  // Unmasked vector arithmetic where src is vs1 or rs1 depending on funct3
  function automatic logic [31:0] enc_valu(input logic [5:0] funct6, input logic [2:0] funct3,
                                           input logic [4:0] vd, input logic [4:0] vs2,
                                           input logic [4:0] src);
    return {funct6, 1'b1, vs2, src, funct3, vd, 7'h57};
  endfunction

  function automatic int check_val(input string name, input string what,
                                   input logic [31:0] exp_v, input logic [31:0] act_v);
    assert (act_v === exp_v) else begin
      $display("** Error: %s %s expected %0h actual %0h", name, what, exp_v, act_v);
    end
    return (act_v === exp_v) ? 0 : 1;
  endfunction

  task automatic report_row(input string name, input int fails);
    tests++;
    errors += fails;
    $display("%-18s %s", name, (fails == 0) ? "ok" : "mismatch");
  endtask

  task automatic add_row(input string name, input logic [31:0] inst, input logic [31:0] rs1,
                         input logic [31:0] rs2, input int kind, input logic [31:0] vl,
                         input logic [2:0] sew, input logic [2:0] lmul, input logic vill,
                         input logic ta, input logic ma, input logic [31:0] cmd_rs1);
    t_name[n_rows]    = name;
    t_inst[n_rows]    = inst;
    t_rs1[n_rows]     = rs1;
    t_rs2[n_rows]     = rs2;
    t_kind[n_rows]    = kind;
    t_vl[n_rows]      = vl;
    t_sew[n_rows]     = sew;
    t_lmul[n_rows]    = lmul;
    t_vill[n_rows]    = vill;
    t_ta[n_rows]      = ta;
    t_ma[n_rows]      = ma;
    t_cmd_rs1[n_rows] = cmd_rs1;
    n_rows++;
  endtask

  // Expected values assume VLEN 128 with LMUL reduction so VLMAX at m1 is 16 >> sew
  // Second line of a row is kind, vl, sew, lmul, vill, ta, ma and command rs1
  task automatic build_table();
    add_row("reset_trap", enc_valu(6'h00, 3'b000, 1, 2, 3), 0, 0,
            K_TRAP, 0, 0, 0, 0, 0, 0, 0);
    add_row("vsetvli_avl100", enc_vsetvli(5, 10, 8'h00), 100, 0,
            K_WB, 16, 0, 0, 0, 0, 0, 0);
    add_row("vsetvli_rs1_x0", enc_vsetvli(5, 0, 8'h00), 0, 0,
            K_WB, 16, 0, 0, 0, 0, 0, 0);
    // vl 5 fits in mf2 at e8
    add_row("vsetvli_avl5", enc_vsetvli(5, 10, 8'h00), 5, 0,
            K_WB, 5, 0, 7, 0, 0, 0, 0);
    add_row("vsetvli_keep_vl", enc_vsetvli(0, 0, 8'h08), 0, 0,
            K_WB, 5, 1, 0, 0, 0, 0, 0);
    add_row("vsetivli_uimm3", enc_vsetivli(6, 3, 8'h91), 0, 0,
            K_WB, 3, 2, 0, 0, 0, 1, 0);
    add_row("vsetvl_rs2", enc_vsetvl(7, 11, 12), 20, 32'h4f,
            K_WB, 4, 1, 7, 0, 1, 0, 0);
    // Policy bits are dropped along with the illegal vtype
    add_row("illegal_vtype", enc_vsetvli(8, 10, 8'hd7), 4, 0,
            K_WB, 0, 0, 0, 1, 0, 0, 0);
    add_row("trap_after_vill", enc_valu(6'h00, 3'b100, 1, 2, 10), 7, 0,
            K_TRAP, 0, 0, 0, 0, 0, 0, 0);
    add_row("cfg_e16_m2", enc_vsetvli(9, 10, 8'h09), 12, 0,
            K_WB, 12, 1, 1, 0, 0, 0, 0);
    add_row("vadd_vx", enc_valu(6'h00, 3'b100, 4, 8, 10), 32'h12345678, 0,
            K_CMD, 12, 1, 1, 0, 0, 0, 32'h12345678);
    add_row("vmul_vx", enc_valu(6'h25, 3'b110, 5, 8, 11), 32'hdeadbeef, 0,
            K_CMD, 12, 1, 1, 0, 0, 0, 32'hdeadbeef);
    add_row("vadd_vv", enc_valu(6'h00, 3'b000, 6, 8, 12), 32'h5555aaaa, 0,
            K_CMD, 12, 1, 1, 0, 0, 0, 32'h0);
    for (int k = 0; k < CMD_DEPTH; k++) begin
      add_row($sformatf("bp_cmd%0d", k), enc_valu(6'h00, 3'b100, 5'(k), 8, 10), 32'h100 + k, 0,
              K_CMD, 12, 1, 1, 0, 0, 0, 32'h100 + k);
    end
    add_row("bp_after", enc_valu(6'h25, 3'b110, 7, 9, 13), 32'hcafe0017, 0,
            K_CMD, 12, 1, 1, 0, 0, 0, 32'hcafe0017);
  endtask

  task automatic run_row(input int r);
    int waited;
    int fails;
    waited       = 0;
    fails        = 0;
    inst_valid_i = 1'b1;
    inst_data_i  = t_inst[r];
    @(negedge clk);
    while (!inst_ready_o && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!inst_ready_o) begin
      $display("Timeout: %s never saw inst_ready_o go high", t_name[r]);
      timed_out = 1'b1;
    end else begin
      // Accepted on this edge and the operands follow in the slot cycle
      @(posedge clk);
      #2;
      inst_valid_i = 1'b0;
      rs1_valid_i  = 1'b1;
      rs1_data_i   = t_rs1[r];
      rs2_valid_i  = 1'b1;
      rs2_data_i   = t_rs2[r];
      @(negedge clk);
      fails += check_val(t_name[r], "reg_write_valid", t_kind[r] == K_WB, reg_write_valid_o);
      fails += check_val(t_name[r], "trap_valid", t_kind[r] == K_TRAP, trap_valid_o);
      if (t_kind[r] == K_WB) begin
        fails += check_val(t_name[r], "reg_write_addr", t_inst[r][11:7], reg_write_addr_o);
        fails += check_val(t_name[r], "reg_write_data", t_vl[r], reg_write_data_o);
      end
      if (t_kind[r] == K_TRAP) begin
        fails += check_val(t_name[r], "trap_inst", t_inst[r], trap_inst_o);
      end
      @(posedge clk);
      #2;
      rs1_valid_i = 1'b0;
      rs1_data_i  = '0;
      rs2_valid_i = 1'b0;
      rs2_data_i  = '0;
      if (t_kind[r] == K_WB) begin
        fails += check_val(t_name[r], "cfg_vl", t_vl[r], cfg_vl_o);
        fails += check_val(t_name[r], "cfg_sew", t_sew[r], cfg_sew_o);
        fails += check_val(t_name[r], "cfg_lmul", t_lmul[r], cfg_lmul_o);
        fails += check_val(t_name[r], "cfg_vill", t_vill[r], cfg_vill_o);
        fails += check_val(t_name[r], "cfg_ta", t_ta[r], cfg_ta_o);
        fails += check_val(t_name[r], "cfg_ma", t_ma[r], cfg_ma_o);
        fails += check_val(t_name[r], "config_valid", 1, config_valid_o);
      end
      if (t_kind[r] == K_CMD) begin
        row_fails[r] = fails;
        exp_q.push_back(r);
      end else begin
        report_row(t_name[r], fails);
      end
    end
  endtask

  task automatic wait_drain(input string name);
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("Timeout: %s, commands still pending on cmd_valid_o", name);
      timed_out = 1'b1;
    end
  endtask

  task automatic set_stall(input logic hold);
    @(negedge clk);
    stall_hold = hold;
    @(posedge clk);
    #2;
  endtask

  // Consumer with random stalls that checks each command as it transfers
  always begin : consumer
    int r;
    int fails;
    @(posedge clk);
    #2;
    rnd_state   = next_random(rnd_state);
    cmd_ready_i = !stall_hold && (rnd_state[1:0] != 2'b00);
    @(negedge clk);
    if (cmd_valid_o && cmd_ready_i) begin
      assert (exp_q.size() != 0) else begin
        $display("Command %h came out with no instruction issued for it", cmd_inst_o);
      end
      if (exp_q.size() == 0) begin
        errors++;
      end else begin
        r     = exp_q.pop_front();
        fails = row_fails[r];
        fails += check_val(t_name[r], "cmd_inst", t_inst[r], cmd_inst_o);
        fails += check_val(t_name[r], "cmd_rs1", t_cmd_rs1[r], cmd_rs1_o);
        fails += check_val(t_name[r], "cmd_vl", t_vl[r], cmd_vl_o);
        fails += check_val(t_name[r], "cmd_sew", t_sew[r], cmd_sew_o);
        fails += check_val(t_name[r], "cmd_lmul", t_lmul[r], cmd_lmul_o);
        report_row(t_name[r], fails);
      end
    end
  end

  initial begin : main
    int fails;
    clk          = 1'b0;
    rstn         = 1'b0;
    inst_valid_i = 1'b0;
    inst_data_i  = '0;
    rs1_valid_i  = 1'b0;
    rs1_data_i   = '0;
    rs2_valid_i  = 1'b0;
    rs2_data_i   = '0;
    cmd_ready_i  = 1'b0;
    stall_hold   = 1'b0;
    timed_out    = 1'b0;
    errors       = 0;
    tests        = 0;
    n_rows       = 0;
    rnd_state    = 32'hf7d7;
    build_table();
    repeat (16) @(posedge clk);
    #2;
    rstn = 1'b1;
    @(negedge clk);
    fails = 0;
    fails += check_val("reset_state", "config_valid", 1, config_valid_o);
    fails += check_val("reset_state", "cfg_vill", 1, cfg_vill_o);
    fails += check_val("reset_state", "cfg_vl", 0, cfg_vl_o);
    fails += check_val("reset_state", "inst_ready", 1, inst_ready_o);
    fails += check_val("reset_state", "cmd_valid", 0, cmd_valid_o);
    fails += check_val("reset_state", "reg_write_valid", 0, reg_write_valid_o);
    fails += check_val("reset_state", "trap_valid", 0, trap_valid_o);
    report_row("reset_state", fails);
    @(posedge clk);
    #2;
    for (int r = 0; r < N_MAIN; r++) begin
      if (!timed_out) begin
        run_row(r);
      end
    end
    if (!timed_out) begin
      wait_drain("main sequence");
    end
    // Fill the FIFO with the consumer stalled
    if (!timed_out) begin
      set_stall(1'b1);
      for (int r = N_MAIN; r < N_MAIN + CMD_DEPTH; r++) begin
        if (!timed_out) begin
          run_row(r);
        end
      end
    end
    if (!timed_out) begin
      fails = check_val("bp_full", "inst_ready", 0, inst_ready_o);
      report_row("bp_full", fails);
      set_stall(1'b0);
      run_row(n_rows - 1);
    end
    if (!timed_out) begin
      wait_drain("back-pressure drain");
    end
    if (!timed_out) begin
      fails = check_val("drained", "cmd_valid", 0, cmd_valid_o);
      report_row("drained", fails);
    end
    $display("Summary: %0d tests, %0d errors, timeout %0d", tests, errors, timed_out);
    if (!timed_out && errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- compile.f
hdl/rvv_cfg_pkg.sv
hdl/rvv_inst_pkg.sv
hdl/rvv_vtype_unit.sv
hdl/rvv_dispatch_stage.sv
hdl/rvv_cmd_fifo.sv
hdl/rvv_front_end.sv
verif/tb_rvv_front_end.sv

//--- Bender.yml
package:
  name: rvv_front_end

sources:
  - hdl/rvv_cfg_pkg.sv
  - hdl/rvv_inst_pkg.sv
  - hdl/rvv_vtype_unit.sv
  - hdl/rvv_dispatch_stage.sv
  - hdl/rvv_cmd_fifo.sv
  - hdl/rvv_front_end.sv
  - target: test
    files:
      - verif/tb_rvv_front_end.sv
